/* hw/l2_defs.svh */
`ifndef L2_DEFS_SVH
`define L2_DEFS_SVH

// Width of one cache line in bits
`define L2_LINE_W 128

// Lines held by the backing store
`define L2_LINES 256

// Entries per request queue
`define L2_DEPTH 8

// Minimum cycles from acceptance to issue
`define L2_DELAY 12

`endif

/* hw/l2_pkg.sv */
`include "l2_defs.svh"

package l2_pkg;

    // One full line and its byte enables
    typedef logic [`L2_LINE_W-1:0]   line_t;
    typedef logic [`L2_LINE_W/8-1:0] be_t;

    // Index into the line array
    typedef logic [7:0] line_addr_t;

    // Request identifier, echoed on the response
    typedef logic [7:0] tag_t;

    // Free-running cycle count used as timestamp
    typedef logic [31:0] stamp_t;

    // Low word of a line, the target of atomics
    typedef logic [63:0] word_t;

    typedef enum logic [1:0] {
        AMO_ADD  = 2'd0,
        AMO_SWAP = 2'd1,
        AMO_AND  = 2'd2,
        AMO_OR   = 2'd3
    } amo_op_e;

endpackage

/* hw/req_queue.sv */
`timescale 1ns/1ps
`include "l2_defs.svh"

module req_queue (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               push_i,
    input  logic               pop_i,
    input  l2_pkg::line_addr_t addr_i,
    input  l2_pkg::tag_t       tag_i,
    input  l2_pkg::line_t      data_i,
    input  l2_pkg::be_t        be_i,
    input  logic               atomic_i,
    input  l2_pkg::amo_op_e    op_i,
    input  l2_pkg::stamp_t     stamp_i,
    output l2_pkg::line_addr_t addr_o,
    output l2_pkg::tag_t       tag_o,
    output l2_pkg::line_t      data_o,
    output l2_pkg::be_t        be_o,
    output logic               atomic_o,
    output l2_pkg::amo_op_e    op_o,
    output l2_pkg::stamp_t     stamp_o,
    output logic               full_o,
    output logic               empty_o
);
    import l2_pkg::*;

    localparam int PTR_W = $clog2(`L2_DEPTH);
    // One extra bit so the count can reach the full depth
    localparam int CNT_W = $clog2(`L2_DEPTH + 1);

    line_addr_t addr_q   [`L2_DEPTH];
    tag_t       tag_q    [`L2_DEPTH];
    line_t      data_q   [`L2_DEPTH];
    be_t        be_q     [`L2_DEPTH];
    logic       atomic_q [`L2_DEPTH];
    amo_op_e    op_q     [`L2_DEPTH];
    stamp_t     stamp_q  [`L2_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign full_o  = (count == CNT_W'(`L2_DEPTH));
    assign empty_o = (count == '0);

    // Head entry
    assign addr_o   = addr_q[rd_ptr];
    assign tag_o    = tag_q[rd_ptr];
    assign data_o   = data_q[rd_ptr];
    assign be_o     = be_q[rd_ptr];
    assign atomic_o = atomic_q[rd_ptr];
    assign op_o     = op_q[rd_ptr];
    assign stamp_o  = stamp_q[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            addr_q[wr_ptr]   <= addr_i;
            tag_q[wr_ptr]    <= tag_i;
            data_q[wr_ptr]   <= data_i;
            be_q[wr_ptr]     <= be_i;
            atomic_q[wr_ptr] <= atomic_i;
            op_q[wr_ptr]     <= op_i;
            stamp_q[wr_ptr]  <= stamp_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Top must gate push with ready, issue must gate pop with empty
    push_not_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(push_i && full_o));
    pop_not_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(pop_i && empty_o));

endmodule

/* hw/issue_stage.sv */
`timescale 1ns/1ps
`include "l2_defs.svh"

module issue_stage (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  l2_pkg::stamp_t     now_i,
    input  l2_pkg::line_addr_t wr_addr_i,
    input  l2_pkg::tag_t       wr_tag_i,
    input  l2_pkg::line_t      wr_data_i,
    input  l2_pkg::be_t        wr_be_i,
    input  logic               wr_atomic_i,
    input  l2_pkg::amo_op_e    wr_op_i,
    input  l2_pkg::stamp_t     wr_stamp_i,
    input  logic               wr_empty_i,
    input  l2_pkg::line_addr_t rd_addr_i,
    input  l2_pkg::tag_t       rd_tag_i,
    input  l2_pkg::stamp_t     rd_stamp_i,
    input  logic               rd_empty_i,
    input  logic               rd_resp_ready_i,
    input  logic               wr_resp_ready_i,
    output logic               wr_pop_o,
    output logic               rd_pop_o,
    output logic               iss_valid_o,
    output logic               iss_write_o,
    output logic               iss_atomic_o,
    output l2_pkg::line_addr_t iss_addr_o,
    output l2_pkg::tag_t       iss_tag_o,
    output l2_pkg::line_t      iss_data_o,
    output l2_pkg::be_t        iss_be_o,
    output l2_pkg::amo_op_e    iss_op_o
);
    import l2_pkg::*;

    logic wr_due;
    logic rd_due;

    assign wr_due = !wr_empty_i && (now_i >= wr_stamp_i + `L2_DELAY);
    assign rd_due = !rd_empty_i && (now_i >= rd_stamp_i + `L2_DELAY);

    // Atomics answer on both ports, so both readies are needed
    assign wr_pop_o = wr_due && wr_resp_ready_i && (!wr_atomic_i || rd_resp_ready_i);
    assign rd_pop_o = rd_due && rd_resp_ready_i && !wr_pop_o;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            iss_valid_o  <= 1'b0;
            iss_write_o  <= 1'b0;
            iss_atomic_o <= 1'b0;
        end else begin
            iss_valid_o  <= wr_pop_o || rd_pop_o;
            iss_write_o  <= wr_pop_o;
            iss_atomic_o <= wr_pop_o && wr_atomic_i;
        end
    end

    always_ff @(posedge clk_i) begin
        iss_addr_o <= wr_pop_o ? wr_addr_i : rd_addr_i;
        iss_tag_o  <= wr_pop_o ? wr_tag_i : rd_tag_i;
        iss_data_o <= wr_data_i;
        iss_be_o   <= wr_be_i;
        iss_op_o   <= wr_op_i;
    end

    single_pop: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(wr_pop_o && rd_pop_o));

endmodule

/* hw/line_store.sv */
`timescale 1ns/1ps
`include "l2_defs.svh"

module line_store (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               iss_valid_i,
    input  logic               iss_write_i,
    input  logic               iss_atomic_i,
    input  l2_pkg::line_addr_t iss_addr_i,
    input  l2_pkg::tag_t       iss_tag_i,
    input  l2_pkg::line_t      iss_data_i,
    input  l2_pkg::be_t        iss_be_i,
    input  l2_pkg::amo_op_e    iss_op_i,
    output logic               done_valid_o,
    output logic               done_write_o,
    output logic               done_atomic_o,
    output l2_pkg::tag_t       done_tag_o,
    output l2_pkg::line_t      done_line_o
);
    import l2_pkg::*;

    line_t mem [`L2_LINES];

    line_t old_line;
    line_t merged_line;
    line_t amo_line;
    word_t old_word;
    word_t req_word;
    word_t new_word;

    assign old_line = mem[iss_addr_i];
    assign old_word = old_line[63:0];
    assign req_word = iss_data_i[63:0];

    // Byte-enable merge for plain writes
    always_comb begin
        merged_line = old_line;
        for (int i = 0; i < `L2_LINE_W/8; i++) begin
            if (iss_be_i[i]) begin
                merged_line[i*8 +: 8] = iss_data_i[i*8 +: 8];
            end
        end
    end

    // Atomic result on the low word only
    always_comb begin
        new_word = old_word;
        case (iss_op_i)
            AMO_ADD:  new_word = old_word + req_word;
            AMO_SWAP: new_word = req_word;
            AMO_AND:  new_word = old_word & req_word;
            AMO_OR:   new_word = old_word | req_word;
            default:  new_word = old_word;
        endcase
        amo_line = {old_line[`L2_LINE_W-1:64], new_word};
    end

    always_ff @(posedge clk_i) begin
        if (iss_valid_i && iss_write_i) begin
            mem[iss_addr_i] <= iss_atomic_i ? amo_line : merged_line;
        end
    end

    // Old line goes out during the issue cycle, update lands at its end
    assign done_valid_o  = iss_valid_i;
    assign done_write_o  = iss_write_i;
    assign done_atomic_o = iss_atomic_i;
    assign done_tag_o    = iss_tag_i;
    assign done_line_o   = old_line;

    atomic_is_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (iss_valid_i && iss_atomic_i) |-> iss_write_i);

endmodule

/* hw/resp_stage.sv */
`timescale 1ns/1ps

module resp_stage (
    input  logic          clk_i,
    input  logic          rstn_i,
    input  logic          done_valid_i,
    input  logic          done_write_i,
    input  logic          done_atomic_i,
    input  l2_pkg::tag_t  done_tag_i,
    input  l2_pkg::line_t done_line_i,
    output logic          rd_resp_valid_o,
    output l2_pkg::tag_t  rd_resp_tag_o,
    output l2_pkg::line_t rd_resp_data_o,
    output logic          wr_resp_valid_o,
    output l2_pkg::tag_t  wr_resp_tag_o,
    output logic          wr_resp_is_atomic_o
);
    import l2_pkg::*;

    logic rd_hit;
    logic wr_hit;

    // Reads and atomics return a line, writes and atomics get an ack
    assign rd_hit = done_valid_i && (!done_write_i || done_atomic_i);
    assign wr_hit = done_valid_i && done_write_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rd_resp_valid_o     <= 1'b0;
            rd_resp_tag_o       <= '0;
            rd_resp_data_o      <= '0;
            wr_resp_valid_o     <= 1'b0;
            wr_resp_tag_o       <= '0;
            wr_resp_is_atomic_o <= 1'b0;
        end else begin
            rd_resp_valid_o     <= rd_hit;
            rd_resp_tag_o       <= rd_hit ? done_tag_i : '0;
            rd_resp_data_o      <= rd_hit ? done_line_i : '0;
            wr_resp_valid_o     <= wr_hit;
            wr_resp_tag_o       <= wr_hit ? done_tag_i : '0;
            wr_resp_is_atomic_o <= wr_hit && done_atomic_i;
        end
    end

endmodule

/* hw/l2_latency_model.sv */
`timescale 1ns/1ps

module l2_latency_model (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               rd_valid_i,
    output logic               rd_ready_o,
    input  l2_pkg::line_addr_t rd_addr_i,
    input  l2_pkg::tag_t       rd_tag_i,
    input  logic               wr_valid_i,
    output logic               wr_ready_o,
    input  l2_pkg::line_addr_t wr_addr_i,
    input  l2_pkg::tag_t       wr_tag_i,
    input  l2_pkg::line_t      wr_data_i,
    input  l2_pkg::be_t        wr_be_i,
    input  logic               wr_is_atomic_i,
    input  l2_pkg::amo_op_e    wr_amo_op_i,
    input  logic               rd_resp_ready_i,
    output logic               rd_resp_valid_o,
    output l2_pkg::tag_t       rd_resp_tag_o,
    output l2_pkg::line_t      rd_resp_data_o,
    input  logic               wr_resp_ready_i,
    output logic               wr_resp_valid_o,
    output l2_pkg::tag_t       wr_resp_tag_o,
    output logic               wr_resp_is_atomic_o
);
    import l2_pkg::*;

    stamp_t     now;
    logic       rd_full, rd_empty, rd_pop;
    logic       wr_full, wr_empty, wr_pop;
    line_addr_t rd_head_addr, wr_head_addr;
    tag_t       rd_head_tag, wr_head_tag;
    stamp_t     rd_head_stamp, wr_head_stamp;
    line_t      wr_head_data;
    be_t        wr_head_be;
    logic       wr_head_atomic;
    amo_op_e    wr_head_op;

    logic       iss_valid, iss_write, iss_atomic;
    line_addr_t iss_addr;
    tag_t       iss_tag;
    line_t      iss_data;
    be_t        iss_be;
    amo_op_e    iss_op;

    logic       done_valid, done_write, done_atomic;
    tag_t       done_tag;
    line_t      done_line;

    // Timestamp source
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            now <= '0;
        end else begin
            now <= now + 1'b1;
        end
    end

    assign rd_ready_o = !rd_full;
    assign wr_ready_o = !wr_full;

    req_queue rd_queue (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .push_i(rd_valid_i && rd_ready_o), .pop_i(rd_pop),
        .addr_i(rd_addr_i), .tag_i(rd_tag_i), .data_i('0), .be_i('0),
        .atomic_i(1'b0), .op_i(AMO_ADD), .stamp_i(now),
        .addr_o(rd_head_addr), .tag_o(rd_head_tag), .data_o(), .be_o(),
        .atomic_o(), .op_o(), .stamp_o(rd_head_stamp),
        .full_o(rd_full), .empty_o(rd_empty)
    );

    req_queue wr_queue (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .push_i(wr_valid_i && wr_ready_o), .pop_i(wr_pop),
        .addr_i(wr_addr_i), .tag_i(wr_tag_i), .data_i(wr_data_i), .be_i(wr_be_i),
        .atomic_i(wr_is_atomic_i), .op_i(wr_amo_op_i), .stamp_i(now),
        .addr_o(wr_head_addr), .tag_o(wr_head_tag), .data_o(wr_head_data),
        .be_o(wr_head_be), .atomic_o(wr_head_atomic), .op_o(wr_head_op),
        .stamp_o(wr_head_stamp), .full_o(wr_full), .empty_o(wr_empty)
    );

    issue_stage u_issue (
        .clk_i(clk_i), .rstn_i(rstn_i), .now_i(now),
        .wr_addr_i(wr_head_addr), .wr_tag_i(wr_head_tag), .wr_data_i(wr_head_data),
        .wr_be_i(wr_head_be), .wr_atomic_i(wr_head_atomic), .wr_op_i(wr_head_op),
        .wr_stamp_i(wr_head_stamp), .wr_empty_i(wr_empty),
        .rd_addr_i(rd_head_addr), .rd_tag_i(rd_head_tag),
        .rd_stamp_i(rd_head_stamp), .rd_empty_i(rd_empty),
        .rd_resp_ready_i(rd_resp_ready_i), .wr_resp_ready_i(wr_resp_ready_i),
        .wr_pop_o(wr_pop), .rd_pop_o(rd_pop),
        .iss_valid_o(iss_valid), .iss_write_o(iss_write), .iss_atomic_o(iss_atomic),
        .iss_addr_o(iss_addr), .iss_tag_o(iss_tag), .iss_data_o(iss_data),
        .iss_be_o(iss_be), .iss_op_o(iss_op)
    );

    line_store u_store (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .iss_valid_i(iss_valid), .iss_write_i(iss_write), .iss_atomic_i(iss_atomic),
        .iss_addr_i(iss_addr), .iss_tag_i(iss_tag), .iss_data_i(iss_data),
        .iss_be_i(iss_be), .iss_op_i(iss_op),
        .done_valid_o(done_valid), .done_write_o(done_write),
        .done_atomic_o(done_atomic), .done_tag_o(done_tag), .done_line_o(done_line)
    );

    resp_stage u_resp (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .done_valid_i(done_valid), .done_write_i(done_write),
        .done_atomic_i(done_atomic), .done_tag_i(done_tag), .done_line_i(done_line),
        .rd_resp_valid_o(rd_resp_valid_o), .rd_resp_tag_o(rd_resp_tag_o),
        .rd_resp_data_o(rd_resp_data_o), .wr_resp_valid_o(wr_resp_valid_o),
        .wr_resp_tag_o(wr_resp_tag_o), .wr_resp_is_atomic_o(wr_resp_is_atomic_o)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rstn_o
);

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // Reset held for 8 cycles, released on a falling edge
    initial begin
        rstn_o = 1'b0;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

/* verification/tb_l2_latency_model.sv */
`timescale 1ns/1ps
`include "l2_defs.svh"

module tb_l2_latency_model;
    import l2_pkg::*;

    localparam int N_FILL = `L2_LINES;
    localparam int N_BE = 20;
    localparam int N_AMO = 12;
    localparam int N_MIX = 120;
    localparam int N_REQS = N_FILL + 1 + 2 * N_BE + 2 * N_AMO + 2 * `L2_DEPTH + 2 * N_MIX;
    localparam int WATCHDOG_CYCLES = N_REQS * (`L2_DELAY + 2 + `L2_DEPTH) * 4;

    logic       clk;
    logic       rstn;
    logic       rd_valid;
    logic       rd_ready;
    line_addr_t rd_addr;
    tag_t       rd_tag;
    logic       wr_valid;
    logic       wr_ready;
    line_addr_t wr_addr;
    tag_t       wr_tag;
    line_t      wr_data;
    be_t        wr_be;
    logic       wr_atomic;
    amo_op_e    wr_op;
    logic       rd_resp_ready;
    logic       rd_resp_valid;
    tag_t       rd_resp_tag;
    line_t      rd_resp_data;
    logic       wr_resp_ready;
    logic       wr_resp_valid;
    tag_t       wr_resp_tag;
    logic       wr_resp_atomic;

    // Reference memory and expected responses per port
    line_t  model_mem [`L2_LINES];
    tag_t   rd_exp_tag[$];
    line_t  rd_exp_line[$];
    tag_t   wr_exp_tag[$];
    logic   wr_exp_atomic[$];
    tag_t   next_rd_tag;
    tag_t   next_wr_tag;
    integer seed;
    string  test_name;

    tb_clock_gen u_clk (.clk_o(clk), .rstn_o(rstn));

    l2_latency_model DUT (
        .clk_i(clk), .rstn_i(rstn),
        .rd_valid_i(rd_valid), .rd_ready_o(rd_ready), .rd_addr_i(rd_addr), .rd_tag_i(rd_tag),
        .wr_valid_i(wr_valid), .wr_ready_o(wr_ready), .wr_addr_i(wr_addr), .wr_tag_i(wr_tag),
        .wr_data_i(wr_data), .wr_be_i(wr_be), .wr_is_atomic_i(wr_atomic), .wr_amo_op_i(wr_op),
        .rd_resp_ready_i(rd_resp_ready), .rd_resp_valid_o(rd_resp_valid),
        .rd_resp_tag_o(rd_resp_tag), .rd_resp_data_o(rd_resp_data),
        .wr_resp_ready_i(wr_resp_ready), .wr_resp_valid_o(wr_resp_valid),
        .wr_resp_tag_o(wr_resp_tag), .wr_resp_is_atomic_o(wr_resp_atomic)
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_line(input string what, input line_t exp, input line_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act));
        end
    endtask

    task automatic check_tag(input string what, input tag_t exp, input tag_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s %s: expected %b, actual %b", test_name, what, exp, act));
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, exp, act));
        end
    endtask

    // Every byte of the pattern depends on the full line index
    function automatic line_t fill_pattern(input line_addr_t a);
        return {4{a, ~a, a ^ 8'h5a, a + 8'd17}};
    endfunction

    function automatic line_t random_line();
        line_t v;
        for (int i = 0; i < `L2_LINE_W / 32; i++) begin
            v[i*32 +: 32] = $random(seed);
        end
        return v;
    endfunction

    function automatic line_t merge_bytes(input line_t old, input line_t data, input be_t be);
        line_t mask;
        for (int i = 0; i < `L2_LINE_W / 8; i++) begin
            mask[8*i +: 8] = {8{be[i]}};
        end
        return (old & ~mask) | (data & mask);
    endfunction

    function automatic line_t apply_atomic(input line_t old, input line_t data, input amo_op_e op);
        word_t a;
        word_t b;
        word_t r;
        a = old[63:0];
        b = data[63:0];
        case (op)
            AMO_ADD:  r = a + b;
            AMO_SWAP: r = b;
            AMO_AND:  r = a & b;
            default:  r = a | b;
        endcase
        return {old[`L2_LINE_W-1:64], r};
    endfunction

    // Called on a falling edge; ready there is what the next rising edge sees
    task automatic offer_read(input line_addr_t a, output bit accepted);
        rd_valid = 1'b1;
        rd_addr = a;
        rd_tag = next_rd_tag;
        accepted = rd_ready;
        if (accepted) begin
            rd_exp_tag.push_back(next_rd_tag);
            rd_exp_line.push_back(model_mem[a]);
            next_rd_tag = next_rd_tag + 8'd1;
        end
    endtask

    task automatic offer_write(input line_addr_t a, input line_t data, input be_t be,
                               input logic atomic, input amo_op_e op, output bit accepted);
        wr_valid = 1'b1;
        wr_addr = a;
        wr_tag = next_wr_tag;
        wr_data = data;
        wr_be = be;
        wr_atomic = atomic;
        wr_op = op;
        accepted = wr_ready;
        if (accepted) begin
            wr_exp_tag.push_back(next_wr_tag);
            wr_exp_atomic.push_back(atomic);
            if (atomic) begin
                // Old line comes back on the read port
                rd_exp_tag.push_back(next_wr_tag);
                rd_exp_line.push_back(model_mem[a]);
                model_mem[a] = apply_atomic(model_mem[a], data, op);
            end else begin
                model_mem[a] = merge_bytes(model_mem[a], data, be);
            end
            next_wr_tag = next_wr_tag + 8'd1;
        end
    endtask

    task automatic send_read(input line_addr_t a);
        bit acc;
        acc = 1'b0;
        while (!acc) begin
            @(negedge clk);
            offer_read(a, acc);
        end
    endtask

    task automatic send_write(input line_addr_t a, input line_t data, input be_t be,
                              input logic atomic, input amo_op_e op);
        bit acc;
        acc = 1'b0;
        while (!acc) begin
            @(negedge clk);
            offer_write(a, data, be, atomic, op, acc);
        end
    endtask

    task automatic release_requests();
        @(negedge clk);
        rd_valid = 1'b0;
        wr_valid = 1'b0;
        rd_resp_ready = 1'b1;
        wr_resp_ready = 1'b1;
    endtask

    task automatic wait_drained();
        @(posedge clk);
        while (rd_exp_tag.size() != 0 || wr_exp_tag.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // Response monitor, in order per port
    always @(negedge clk) begin
        if (rstn === 1'b1) begin
            if (rd_resp_valid) begin
                if (rd_exp_tag.size() == 0) begin
                    abort_run("Read response arrived with no request outstanding");
                end else begin
                    check_tag("rd_resp_tag", rd_exp_tag.pop_front(), rd_resp_tag);
                    check_line("rd_resp_data", rd_exp_line.pop_front(), rd_resp_data);
                end
            end
            if (wr_resp_valid) begin
                if (wr_exp_tag.size() == 0) begin
                    abort_run("Write response arrived with no request outstanding");
                end else begin
                    check_tag("wr_resp_tag", wr_exp_tag.pop_front(), wr_resp_tag);
                    check_flag("wr_resp_is_atomic", wr_exp_atomic.pop_front(), wr_resp_atomic);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("Timeout: responses still missing after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        bit          acc;
        int          lat;
        int          rd_count;
        int          wr_count;
        bit          rd_drop;
        bit          wr_drop;
        line_addr_t  a;
        line_addr_t  touched[$];
        logic [31:0] r;
        logic [31:0] r2;

        seed = 32'h9eaa;
        rd_valid = 1'b0;
        rd_addr = '0;
        rd_tag = '0;
        wr_valid = 1'b0;
        wr_addr = '0;
        wr_tag = '0;
        wr_data = '0;
        wr_be = '0;
        wr_atomic = 1'b0;
        wr_op = AMO_ADD;
        rd_resp_ready = 1'b1;
        wr_resp_ready = 1'b1;
        next_rd_tag = '0;
        next_wr_tag = '0;
        for (int i = 0; i < `L2_LINES; i++) begin
            model_mem[i] = '0;
        end

        test_name = "reset_state";
        while (rstn !== 1'b1) begin
            @(negedge clk);
            check_flag("rd_resp_valid", 1'b0, rd_resp_valid);
            check_flag("wr_resp_valid", 1'b0, wr_resp_valid);
            check_flag("rd_ready", 1'b1, rd_ready);
            check_flag("wr_ready", 1'b1, wr_ready);
        end
        repeat (2) begin
            @(negedge clk);
            check_flag("rd_resp_valid", 1'b0, rd_resp_valid);
            check_flag("wr_resp_valid", 1'b0, wr_resp_valid);
            check_flag("rd_ready", 1'b1, rd_ready);
            check_flag("wr_ready", 1'b1, wr_ready);
        end

        // Known contents for every line
        test_name = "fill";
        for (int i = 0; i < N_FILL; i++) begin
            send_write(line_addr_t'(i), fill_pattern(line_addr_t'(i)), '1, 1'b0, AMO_ADD);
        end
        release_requests();
        wait_drained();

        test_name = "single_read_latency";
        r = $random(seed);
        a = r[7:0];
        @(negedge clk);
        offer_read(a, acc);
        check_flag("rd_ready", 1'b1, acc);
        lat = 0;
        while (lat == 0 || (!rd_resp_valid && lat < 4 * `L2_DELAY)) begin
            @(negedge clk);
            rd_valid = 1'b0;
            lat++;
        end
        check_count("latency", `L2_DELAY + 2, lat);
        check_line("initial line", fill_pattern(a), rd_resp_data);
        wait_drained();

        test_name = "byte_enable_writes";
        for (int i = 0; i < N_BE; i++) begin
            r = $random(seed);
            r2 = $random(seed);
            send_write(r[7:0], random_line(), r2[`L2_LINE_W/8-1:0], 1'b0, AMO_ADD);
            touched.push_back(r[7:0]);
        end
        release_requests();
        wait_drained();
        foreach (touched[i]) begin
            send_read(touched[i]);
        end
        release_requests();
        wait_drained();

        test_name = "atomics";
        touched.delete();
        for (int i = 0; i < N_AMO; i++) begin
            r = $random(seed);
            send_write(r[7:0], random_line(), r[31:16], 1'b1, amo_op_e'(r[9:8]));
            touched.push_back(r[7:0]);
        end
        release_requests();
        wait_drained();
        foreach (touched[i]) begin
            send_read(touched[i]);
        end
        release_requests();
        wait_drained();

        // Reads on the lower half, writes on the upper half
        test_name = "back_pressure";
        @(negedge clk);
        rd_resp_ready = 1'b0;
        wr_resp_ready = 1'b0;
        rd_count = 0;
        wr_count = 0;
        rd_drop = 1'b0;
        wr_drop = 1'b0;
        for (int i = 0; i < 2 * `L2_DEPTH + `L2_DELAY + 4; i++) begin
            @(negedge clk);
            check_flag("rd_resp_valid", 1'b0, rd_resp_valid);
            check_flag("wr_resp_valid", 1'b0, wr_resp_valid);
            if (!rd_ready && !rd_drop) begin
                check_count("reads accepted", `L2_DEPTH, rd_count);
                rd_drop = 1'b1;
            end
            if (!wr_ready && !wr_drop) begin
                check_count("writes accepted", `L2_DEPTH, wr_count);
                wr_drop = 1'b1;
            end
            r = $random(seed);
            offer_read({1'b0, r[6:0]}, acc);
            if (acc) rd_count++;
            offer_write({1'b1, r[14:8]}, random_line(), r[31:16], 1'b0, AMO_ADD, acc);
            if (acc) wr_count++;
        end
        if (!rd_drop || !wr_drop) begin
            abort_run("A request ready stayed high while its queue should be full");
        end
        release_requests();
        wait_drained();

        test_name = "mixed_traffic";
        for (int i = 0; i < N_MIX; i++) begin
            @(negedge clk);
            r = $random(seed);
            rd_resp_ready = r[0] | r[1];
            wr_resp_ready = r[2] | r[3];
            if (r[4]) begin
                offer_read({1'b0, r[14:8]}, acc);
            end else begin
                rd_valid = 1'b0;
            end
            if (r[5]) begin
                r2 = $random(seed);
                offer_write({1'b1, r[22:16]}, random_line(), r2[15:0], 1'b0, AMO_ADD, acc);
            end else begin
                wr_valid = 1'b0;
            end
        end
        release_requests();
        wait_drained();

        $display("Regression passed");
        $finish;
    end

endmodule

/* l2_latency_model.f */
+incdir+hw
hw/l2_pkg.sv
hw/req_queue.sv
hw/issue_stage.sv
hw/line_store.sv
hw/resp_stage.sv
hw/l2_latency_model.sv
verification/tb_clock_gen.sv
verification/tb_l2_latency_model.sv

/* Makefile */
TOP := tb_l2_latency_model

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): l2_latency_model.f hw/*.sv hw/*.svh verification/*.sv
	verilator --binary --timing --assert -j 0 -f l2_latency_model.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

lint:
	verilator --lint-only --timing --assert -f l2_latency_model.f --top-module $(TOP)

clean:
	rm -rf obj_dir
